// ==== verilog/hash_map_cfg.svh ====
// Size and hash settings of the key-to-data store
`ifndef HASH_MAP_CFG_SVH
`define HASH_MAP_CFG_SVH

// Width of a key
`define HM_KEY_BITS 32

// Width of the data stored with each key
`define HM_DAT_BITS 8

// Bucket-head entries, addressed by the low hash bits
`define HM_BUCKETS 8

// Chain nodes for colliding keys
// Address 0 marks the end of a chain, so one entry less is usable
`define HM_CHAIN_NODES 8

// CRC-32 generator polynomial, normal form
`define HM_CRC_POLY 32'h04C11DB7

`endif

// ==== verilog/hash_map_pkg.sv ====
// Package with the opcode, address, node, request and response types of the store
`default_nettype none
`include "hash_map_cfg.svh"

package hash_map_pkg;

  typedef enum logic [1:0] {
    OP_LOOKUP = 2'd0,
    OP_ADD    = 2'd1,
    OP_CLEAR  = 2'd2
  } opcode_t;

  typedef logic [$clog2(`HM_BUCKETS)-1:0]     bucket_addr_t;
  typedef logic [$clog2(`HM_CHAIN_NODES)-1:0] chain_addr_t;

  // Same layout in the bucket-head memory and the chain memory
  typedef struct packed {
    logic [`HM_KEY_BITS-1:0] key;
    logic [`HM_DAT_BITS-1:0] dat;
    chain_addr_t             nxt;
    logic                    used;
  } node_t;

  typedef struct packed {
    opcode_t                 op;
    logic [`HM_KEY_BITS-1:0] key;
    logic [`HM_DAT_BITS-1:0] dat;
  } req_t;

  // dat is the stored data of a found key (the old data on an overwrite), else zero
  typedef struct packed {
    logic [`HM_DAT_BITS-1:0] dat;
    logic                    found;
    logic                    full;
  } rsp_t;

endpackage

`default_nettype wire

// ==== verilog/key_hash.sv ====
// Key hasher: combinational CRC-32 fold of the key, registered bucket index and strobe
`default_nettype none
`include "hash_map_cfg.svh"

module key_hash (
  input  logic                       i_clk,
  input  logic                       coll_ram_rst,
  input  logic                       i_start,
  input  logic [`HM_KEY_BITS-1:0]    i_key,
  output hash_map_pkg::bucket_addr_t o_bucket,
  output logic                       o_hash_val
);
  import hash_map_pkg::*;

  localparam int CRC_BITS = 32;

  logic [CRC_BITS-1:0] crc_c;

  // Bit-serial CRC unrolled over the key
  // Zero start value, MSB first, no reflection, no final inversion
  always_comb begin
    crc_c = '0;
    for (int i = `HM_KEY_BITS - 1; i >= 0; i--) begin
      if (crc_c[CRC_BITS-1] ^ i_key[i]) begin
        crc_c = (crc_c << 1) ^ `HM_CRC_POLY;
      end else begin
        crc_c = crc_c << 1;
      end
    end
  end

  // Index is only the low bits of the CRC
  always_ff @(posedge i_clk) begin
    o_bucket <= crc_c[$bits(bucket_addr_t)-1:0];
  end

  always_ff @(posedge i_clk) begin
    if (!coll_ram_rst) begin
      o_hash_val <= 1'b0;
    end else begin
      o_hash_val <= i_start;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/node_alloc.sv ====
// Chain-node allocator: counter over the free chain addresses with an exhaustion flag
`default_nettype none
`include "hash_map_cfg.svh"

module node_alloc (
  input  logic                      i_clk,
  input  logic                      coll_ram_rst,
  input  logic                      i_take,
  input  logic                      i_restart,
  output hash_map_pkg::chain_addr_t o_free_addr,
  output logic                      o_empty
);
  import hash_map_pkg::*;

  // Address 0 never leaves the pool, it terminates every chain
  localparam chain_addr_t FIRST_ADDR = chain_addr_t'(1);
  localparam chain_addr_t LAST_ADDR  = chain_addr_t'(`HM_CHAIN_NODES - 1);

  chain_addr_t next_q;
  logic        empty_q;

  // Nodes are never returned one by one, so the pool only shrinks until a restart
  always_ff @(posedge i_clk) begin
    if (!coll_ram_rst || i_restart) begin
      next_q  <= FIRST_ADDR;
      empty_q <= 1'b0;
    end else if (i_take && !empty_q) begin
      if (next_q == LAST_ADDR) begin
        // Saturate on the last address
        empty_q <= 1'b1;
      end else begin
        next_q <= next_q + chain_addr_t'(1);
      end
    end
  end

  assign o_free_addr = next_q;
  assign o_empty     = empty_q;

endmodule

`default_nettype wire

// ==== verilog/node_ram.sv ====
// Node memory: single-port RAM of node_t entries with write at the edge and registered read
`default_nettype none

module node_ram #(
  parameter int DEPTH = 8
) (
  input  logic                     i_clk,
  input  logic [$clog2(DEPTH)-1:0] i_addr,
  input  logic                     i_we,
  input  hash_map_pkg::node_t      i_wr,
  output hash_map_pkg::node_t      o_rd
);
  import hash_map_pkg::*;

  node_t mem [DEPTH];

  always_ff @(posedge i_clk) begin
    if (i_we) begin
      mem[i_addr] <= i_wr;
    end
  end

  // Read returns the old entry when the same address is written
  always_ff @(posedge i_clk) begin
    o_rd <= mem[i_addr];
  end

endmodule

`default_nettype wire

// ==== verilog/chain_walker.sv ====
// Request FSM: hashes the key, reads the bucket head, walks the chain, writes nodes, clears
`default_nettype none
`include "hash_map_cfg.svh"

module chain_walker (
  input  logic                       i_clk,
  input  logic                       coll_ram_rst,
  input  hash_map_pkg::req_t         i_req,
  input  logic                       i_req_val,
  output logic                       o_rdy,
  output hash_map_pkg::rsp_t         o_rsp,
  output logic                       o_rsp_val,
  output logic                       o_hash_start,
  output logic [`HM_KEY_BITS-1:0]    o_hash_key,
  input  hash_map_pkg::bucket_addr_t i_bucket,
  input  logic                       i_hash_val,
  input  hash_map_pkg::chain_addr_t  i_free_addr,
  input  logic                       i_empty,
  output logic                       o_take,
  output logic                       o_restart,
  output hash_map_pkg::bucket_addr_t o_head_addr,
  output logic                       o_head_we,
  output hash_map_pkg::node_t        o_head_wr,
  input  hash_map_pkg::node_t        i_head_rd,
  output hash_map_pkg::chain_addr_t  o_chain_addr,
  output logic                       o_chain_we,
  output hash_map_pkg::node_t        o_chain_wr,
  input  hash_map_pkg::node_t        i_chain_rd
);
  import hash_map_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_HASH,
    ST_HEAD,
    ST_WALK,
    ST_CLEAR
  } state_t;

  localparam bucket_addr_t LAST_BUCKET = bucket_addr_t'(`HM_BUCKETS - 1);

  state_t       state_q;
  req_t         req_q;
  bucket_addr_t bkt_q;
  chain_addr_t  chain_addr_q;
  logic         wait_q;
  logic         link_q;
  logic         accept;
  logic         head_hit;
  logic         chain_hit;

  function automatic rsp_t mk_rsp(input logic [`HM_DAT_BITS-1:0] rd_dat,
                                  input logic hit, input logic no_room);
    return '{dat: rd_dat, found: hit, full: no_room};
  endfunction

  // Node holding the request's key and data at the end of a chain
  function automatic node_t fresh_node(input req_t r);
    return '{key: r.key, dat: r.dat, nxt: '0, used: 1'b1};
  endfunction

  assign accept       = o_rdy && i_req_val;
  assign o_hash_start = accept && (i_req.op != OP_CLEAR);
  assign o_hash_key   = i_req.key;

  // The head read is issued while the hash is valid, later accesses use the latched bucket
  assign o_head_addr  = (state_q == ST_HASH) ? i_bucket : bkt_q;
  assign o_chain_addr = chain_addr_q;

  assign head_hit  = i_head_rd.used && (i_head_rd.key == req_q.key);
  assign chain_hit = i_chain_rd.used && (i_chain_rd.key == req_q.key);

  always_ff @(posedge i_clk) begin
    if (!coll_ram_rst) begin
      // Reset runs the same sequence as a clear request
      state_q    <= ST_CLEAR;
      bkt_q      <= '0;
      o_rdy      <= 1'b0;
      o_rsp_val  <= 1'b0;
      o_head_we  <= 1'b0;
      o_chain_we <= 1'b0;
      o_take     <= 1'b0;
      o_restart  <= 1'b0;
      wait_q     <= 1'b0;
      link_q     <= 1'b0;
    end else begin
      o_rsp_val  <= 1'b0;
      o_head_we  <= 1'b0;
      o_chain_we <= 1'b0;
      o_take     <= 1'b0;
      o_restart  <= 1'b0;

      case (state_q)
        ST_IDLE: begin
          // Ready comes back one cycle after the response strobe
          if (!o_rdy) begin
            o_rdy <= 1'b1;
          end else if (accept) begin
            o_rdy <= 1'b0;
            req_q <= i_req;
            if (i_req.op == OP_CLEAR) begin
              bkt_q   <= '0;
              state_q <= ST_CLEAR;
            end else begin
              state_q <= ST_HASH;
            end
          end
        end

        ST_HASH: begin
          if (i_hash_val) begin
            bkt_q   <= i_bucket;
            state_q <= ST_HEAD;
          end
        end

        ST_HEAD: begin
          if (!i_head_rd.used) begin
            // Empty bucket, an add fills the head directly
            if (req_q.op == OP_ADD) begin
              o_head_we <= 1'b1;
              o_head_wr <= fresh_node(req_q);
            end
            o_rsp     <= mk_rsp('0, 1'b0, 1'b0);
            o_rsp_val <= 1'b1;
            state_q   <= ST_IDLE;
          end else if (head_hit) begin
            if (req_q.op == OP_ADD) begin
              o_head_we     <= 1'b1;
              o_head_wr     <= i_head_rd;
              o_head_wr.dat <= req_q.dat;
            end
            o_rsp     <= mk_rsp(i_head_rd.dat, 1'b1, 1'b0);
            o_rsp_val <= 1'b1;
            state_q   <= ST_IDLE;
          end else if (i_head_rd.nxt != '0) begin
            chain_addr_q <= i_head_rd.nxt;
            wait_q       <= 1'b1;
            state_q      <= ST_WALK;
          end else if (req_q.op == OP_ADD && !i_empty) begin
            // Head and new node sit in different memories, so both go in one cycle
            o_head_we     <= 1'b1;
            o_head_wr     <= i_head_rd;
            o_head_wr.nxt <= i_free_addr;
            o_chain_we    <= 1'b1;
            chain_addr_q  <= i_free_addr;
            o_chain_wr    <= fresh_node(req_q);
            o_take        <= 1'b1;
            o_rsp         <= mk_rsp('0, 1'b0, 1'b0);
            o_rsp_val     <= 1'b1;
            state_q       <= ST_IDLE;
          end else begin
            // Lookup miss, or an add with no chain node left
            o_rsp     <= mk_rsp('0, 1'b0, req_q.op == OP_ADD);
            o_rsp_val <= 1'b1;
            state_q   <= ST_IDLE;
          end
        end

        ST_WALK: begin
          if (link_q) begin
            // Tail was relinked last cycle, now store the new node itself
            link_q       <= 1'b0;
            o_chain_we   <= 1'b1;
            chain_addr_q <= i_free_addr;
            o_chain_wr   <= fresh_node(req_q);
            o_take       <= 1'b1;
            o_rsp        <= mk_rsp('0, 1'b0, 1'b0);
            o_rsp_val    <= 1'b1;
            state_q      <= ST_IDLE;
          end else if (wait_q) begin
            // One cycle of read latency per node
            wait_q <= 1'b0;
          end else if (chain_hit) begin
            if (req_q.op == OP_ADD) begin
              o_chain_we     <= 1'b1;
              o_chain_wr     <= i_chain_rd;
              o_chain_wr.dat <= req_q.dat;
            end
            o_rsp     <= mk_rsp(i_chain_rd.dat, 1'b1, 1'b0);
            o_rsp_val <= 1'b1;
            state_q   <= ST_IDLE;
          end else if (i_chain_rd.nxt != '0) begin
            chain_addr_q <= i_chain_rd.nxt;
            wait_q       <= 1'b1;
          end else if (req_q.op == OP_ADD && !i_empty) begin
            o_chain_we     <= 1'b1;
            o_chain_wr     <= i_chain_rd;
            o_chain_wr.nxt <= i_free_addr;
            link_q         <= 1'b1;
          end else begin
            o_rsp     <= mk_rsp('0, 1'b0, req_q.op == OP_ADD);
            o_rsp_val <= 1'b1;
            state_q   <= ST_IDLE;
          end
        end

        ST_CLEAR: begin
          // First cycle arms the write, then one bucket per cycle
          o_head_wr <= '0;
          o_head_we <= 1'b1;
          if (o_head_we) begin
            if (bkt_q == LAST_BUCKET) begin
              o_head_we <= 1'b0;
              o_restart <= 1'b1;
              state_q   <= ST_IDLE;
            end else begin
              bkt_q <= bkt_q + bucket_addr_t'(1);
            end
          end
        end

        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== verilog/hash_map.sv ====
// Top level of the store: hasher, allocator, chain walker, bucket-head and chain memories
`default_nettype none
`include "hash_map_cfg.svh"

module hash_map (
  input  logic               i_clk,
  input  logic               coll_ram_rst,
  input  hash_map_pkg::req_t i_req,
  input  logic               i_req_val,
  output logic               o_rdy,
  output hash_map_pkg::rsp_t o_rsp,
  output logic               o_rsp_val,
  output logic               o_cfg_full
);
  import hash_map_pkg::*;

  logic                    hash_start;
  logic [`HM_KEY_BITS-1:0] hash_key;
  bucket_addr_t            bucket;
  logic                    hash_val;
  chain_addr_t             free_addr;
  logic                    empty;
  logic                    take;
  logic                    restart;
  bucket_addr_t            head_addr;
  logic                    head_we;
  node_t                   head_wr;
  node_t                   head_rd;
  chain_addr_t             chain_addr;
  logic                    chain_we;
  node_t                   chain_wr;
  node_t                   chain_rd;

  key_hash u_key_hash (
    .i_clk        (i_clk),
    .coll_ram_rst (coll_ram_rst),
    .i_start      (hash_start),
    .i_key        (hash_key),
    .o_bucket     (bucket),
    .o_hash_val   (hash_val)
  );

  node_alloc u_node_alloc (
    .i_clk        (i_clk),
    .coll_ram_rst (coll_ram_rst),
    .i_take       (take),
    .i_restart    (restart),
    .o_free_addr  (free_addr),
    .o_empty      (empty)
  );

  chain_walker u_chain_walker (
    .i_clk        (i_clk),
    .coll_ram_rst (coll_ram_rst),
    .i_req        (i_req),
    .i_req_val    (i_req_val),
    .o_rdy        (o_rdy),
    .o_rsp        (o_rsp),
    .o_rsp_val    (o_rsp_val),
    .o_hash_start (hash_start),
    .o_hash_key   (hash_key),
    .i_bucket     (bucket),
    .i_hash_val   (hash_val),
    .i_free_addr  (free_addr),
    .i_empty      (empty),
    .o_take       (take),
    .o_restart    (restart),
    .o_head_addr  (head_addr),
    .o_head_we    (head_we),
    .o_head_wr    (head_wr),
    .i_head_rd    (head_rd),
    .o_chain_addr (chain_addr),
    .o_chain_we   (chain_we),
    .o_chain_wr   (chain_wr),
    .i_chain_rd   (chain_rd)
  );

  node_ram #(.DEPTH(`HM_BUCKETS)) head_ram (
    .i_clk  (i_clk),
    .i_addr (head_addr),
    .i_we   (head_we),
    .i_wr   (head_wr),
    .o_rd   (head_rd)
  );

  node_ram #(.DEPTH(`HM_CHAIN_NODES)) chain_ram (
    .i_clk  (i_clk),
    .i_addr (chain_addr),
    .i_we   (chain_we),
    .i_wr   (chain_wr),
    .o_rd   (chain_rd)
  );

  // Full as long as the allocator has no node left
  assign o_cfg_full = empty;

endmodule

`default_nettype wire

// ==== sim/hash_map_assertions.sv ====
// Handshake assertions for the store, bound into the top level
`default_nettype none

module hash_map_assertions (
  input logic i_clk,
  input logic coll_ram_rst,
  input logic i_req_val,
  input logic o_rdy,
  input logic o_rsp_val
);
  timeunit 1ns;
  timeprecision 1ps;

  // Response strobe is a single cycle
  a_rsp_single: assert property (@(posedge i_clk) disable iff (!coll_ram_rst)
    o_rsp_val |=> !o_rsp_val)
    else $error("o_rsp_val stayed high for two cycles");

  // Ready drops right after an accepted request
  a_rdy_drop: assert property (@(posedge i_clk) disable iff (!coll_ram_rst)
    (i_req_val && o_rdy) |=> !o_rdy)
    else $error("o_rdy still high after an accepted request");

  a_rsp_busy: assert property (@(posedge i_clk) disable iff (!coll_ram_rst)
    !(o_rsp_val && o_rdy))
    else $error("o_rsp_val raised while o_rdy is high");

endmodule

bind hash_map hash_map_assertions u_handshake_assert (
  .i_clk        (i_clk),
  .coll_ram_rst (coll_ram_rst),
  .i_req_val    (i_req_val),
  .o_rdy        (o_rdy),
  .o_rsp_val    (o_rsp_val)
);

`default_nettype wire

// ==== sim/hash_map_tb.sv ====
// Testbench for the store: clock, reset, stimulus, reference model, response checks, watchdog
`default_nettype none
`include "hash_map_cfg.svh"

module hash_map_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import hash_map_pkg::*;

  typedef logic [`HM_KEY_BITS-1:0] key_t;
  typedef logic [`HM_DAT_BITS-1:0] dat_t;

  localparam int CLK_PERIOD = 20;
  localparam int RST_CYCLES = 8;
  localparam int N_MISS     = 4;
  localparam int N_FIRST    = 5;
  // Test 2 takes three chain nodes, the rest are filled in test 4
  localparam int N_FILL     = `HM_CHAIN_NODES - 1 - 3;
  localparam int N_REJECT   = 2;
  localparam int N_AFTER    = 3;
  // Exact count of requests issued by the sequence below
  localparam int N_REQ = N_MISS + 2 * N_FIRST + 4 + N_FILL + 2 * N_REJECT + 1
                       + 2 * (N_FIRST + N_FILL + 1) + N_REJECT + 1 + 2 * N_AFTER;
  localparam int RSP_TIMEOUT = 4 + 2 * (`HM_CHAIN_NODES - 1) + 6;
  localparam int RDY_TIMEOUT = `HM_BUCKETS + 8;
  localparam int WATCHDOG_NS = (RST_CYCLES + N_REQ * (RSP_TIMEOUT + 4)
                               + 2 * RDY_TIMEOUT + 10) * CLK_PERIOD;

  logic         i_clk = 1'b0;
  logic         coll_ram_rst;
  req_t         i_req;
  logic         i_req_val;
  logic         o_rdy;
  rsp_t         o_rsp;
  logic         o_rsp_val;
  logic         o_cfg_full;

  integer       seed;
  dat_t         ref_mem [key_t];
  bit           used_keys [key_t];
  bit           head_used [`HM_BUCKETS];
  int           free_nodes;
  rsp_t         exp_q [$];
  logic         full_q [$];
  logic         full_pending;
  logic         full_exp;
  bit           fail_seen;
  bit           run_done;
  key_t         added_q [$];
  key_t         reject_q [$];
  key_t         fresh_q [$];
  key_t         k;
  bucket_addr_t b_a;
  bucket_addr_t b_b;
  bucket_addr_t b_free;

  hash_map dut (
    .i_clk        (i_clk),
    .coll_ram_rst (coll_ram_rst),
    .i_req        (i_req),
    .i_req_val    (i_req_val),
    .o_rdy        (o_rdy),
    .o_rsp        (o_rsp),
    .o_rsp_val    (o_rsp_val),
    .o_cfg_full   (o_cfg_full)
  );

  always #(CLK_PERIOD / 2) i_clk = ~i_clk;

  task automatic fail_run(input string why);
    fail_seen = 1'b1;
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_rsp(input rsp_t got, input rsp_t exp);
    if (got !== exp) begin
      fail_run($sformatf("Error: o_rsp got %h expected %h", got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("Error: %s got %h expected %h", name, got, exp));
    end
  endtask

  // CRC-32, zero start, key MSB first, no reflection or final inversion
  function automatic bucket_addr_t bucket_of(input key_t key);
    logic [31:0] crc;
    logic        fb;
    crc = 32'h0;
    for (int i = `HM_KEY_BITS - 1; i >= 0; i--) begin
      fb  = crc[31] ^ key[i];
      crc = {crc[30:0], 1'b0};
      if (fb) begin
        crc = crc ^ `HM_CRC_POLY;
      end
    end
    return bucket_addr_t'(crc);
  endfunction

  function automatic void reset_model();
    ref_mem.delete();
    foreach (head_used[i]) begin
      head_used[i] = 1'b0;
    end
    free_nodes = `HM_CHAIN_NODES - 1;
  endfunction

  // Expected response of one request, updates the model as the store would
  function automatic rsp_t ref_rsp(input req_t r);
    rsp_t         rsp;
    bucket_addr_t b;
    rsp = '0;
    b   = bucket_of(r.key);
    if (r.op == OP_CLEAR) begin
      reset_model();
    end else if (ref_mem.exists(r.key)) begin
      // Found keys report their stored data, an add reports the old data
      rsp.dat   = ref_mem[r.key];
      rsp.found = 1'b1;
      if (r.op == OP_ADD) begin
        ref_mem[r.key] = r.dat;
      end
    end else if (r.op == OP_ADD) begin
      if (!head_used[b]) begin
        head_used[b]   = 1'b1;
        ref_mem[r.key] = r.dat;
      end else if (free_nodes > 0) begin
        free_nodes--;
        ref_mem[r.key] = r.dat;
      end else begin
        rsp.full = 1'b1;
      end
    end
    return rsp;
  endfunction

  // Random key hashing to bucket b that was never used before
  task automatic pick_key(input bucket_addr_t b, output key_t key);
    key = key_t'($random(seed));
    while (bucket_of(key) != b || used_keys.exists(key)) begin
      key = key_t'($random(seed));
    end
    used_keys[key] = 1'b1;
  endtask

  task automatic send_req(input opcode_t op, input key_t key, input dat_t dat);
    req_t r;
    int   waited;
    r.op   = op;
    r.key  = key;
    r.dat  = dat;
    waited = 0;
    @(posedge i_clk);
    while (!o_rdy) begin
      waited++;
      if (waited > RDY_TIMEOUT) begin
        fail_run("o_rdy did not come back high in time");
      end
      @(posedge i_clk);
    end
    if (op != OP_CLEAR) begin
      exp_q.push_back(ref_rsp(r));
      full_q.push_back(free_nodes == 0);
    end else begin
      void'(ref_rsp(r));
    end
    i_req     <= r;
    i_req_val <= 1'b1;
    @(posedge i_clk);
    i_req_val <= 1'b0;
    waited = 0;
    while (exp_q.size() != 0) begin
      @(negedge i_clk);
      waited++;
      if (waited > RSP_TIMEOUT) begin
        fail_run($sformatf("No response to the request for key %h", key));
      end
    end
  endtask

  // Compares each response, and o_cfg_full once the allocator has settled
  always @(posedge i_clk) begin
    if (full_pending) begin
      check_flag("o_cfg_full", o_cfg_full, full_exp);
      full_pending = 1'b0;
    end
    if (coll_ram_rst === 1'b1 && o_rsp_val === 1'b1) begin
      if (exp_q.size() == 0) begin
        fail_run("Response strobe seen with no request outstanding");
      end else begin
        check_rsp(o_rsp, exp_q.pop_front());
        full_exp     = full_q.pop_front();
        full_pending = 1'b1;
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    fail_run("Timeout: the test sequence did not finish in time");
  end

  // A run stopped by a failed assertion ends here without a verdict
  final begin
    if (!run_done && !fail_seen) begin
      $display("ERRORS FOUND");
    end
  end

  initial begin
    seed         = 87458;
    coll_ram_rst = 1'b0;
    i_req        = '0;
    i_req_val    = 1'b0;
    full_pending = 1'b0;
    fail_seen    = 1'b0;
    run_done     = 1'b0;
    reset_model();
    repeat (RST_CYCLES) @(posedge i_clk);
    coll_ram_rst <= 1'b1;

    // Empty store after reset
    for (int n = 0; n < N_MISS; n++) begin
      pick_key(bucket_addr_t'($random(seed)), k);
      send_req(OP_LOOKUP, k, '0);
    end

    // Three keys in bucket a, two in bucket b
    b_a = bucket_addr_t'($random(seed));
    b_b = b_a + bucket_addr_t'(`HM_BUCKETS / 2);
    for (int n = 0; n < N_FIRST; n++) begin
      pick_key((n < 3) ? b_a : b_b, k);
      send_req(OP_ADD, k, dat_t'($random(seed)));
      added_q.push_back(k);
    end
    foreach (added_q[i]) send_req(OP_LOOKUP, added_q[i], '0);

    // Overwrite a head and a chain tail
    for (int n = 0; n <= 2; n += 2) begin
      send_req(OP_ADD, added_q[n], ~ref_mem[added_q[n]]);
      send_req(OP_LOOKUP, added_q[n], '0);
    end

    // Use up the chain pool, then chained adds are refused
    for (int n = 0; n < N_FILL; n++) begin
      pick_key(b_a, k);
      send_req(OP_ADD, k, dat_t'($random(seed)));
      added_q.push_back(k);
    end
    for (int n = 0; n < N_REJECT; n++) begin
      pick_key((n == 0) ? b_a : b_b, k);
      send_req(OP_ADD, k, dat_t'($random(seed)));
      reject_q.push_back(k);
    end
    // An empty head still accepts a key while the pool is exhausted
    b_free = b_a;
    while (head_used[b_free]) b_free = b_free + bucket_addr_t'(1);
    pick_key(b_free, k);
    send_req(OP_ADD, k, dat_t'($random(seed)));
    added_q.push_back(k);
    foreach (reject_q[i]) send_req(OP_LOOKUP, reject_q[i], '0);
    foreach (added_q[i]) send_req(OP_LOOKUP, added_q[i], '0);

    // Clear empties every bucket and returns the pool
    send_req(OP_CLEAR, '0, '0);
    foreach (added_q[i]) send_req(OP_LOOKUP, added_q[i], '0);
    foreach (reject_q[i]) send_req(OP_LOOKUP, reject_q[i], '0);
    for (int n = 0; n < N_AFTER; n++) begin
      pick_key(b_b, k);
      send_req(OP_ADD, k, dat_t'($random(seed)));
      fresh_q.push_back(k);
    end
    foreach (fresh_q[i]) send_req(OP_LOOKUP, fresh_q[i], '0);

    repeat (3) @(posedge i_clk);
    run_done = 1'b1;
    if (!fail_seen) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+verilog
verilog/hash_map_pkg.sv
verilog/key_hash.sv
verilog/node_alloc.sv
verilog/node_ram.sv
verilog/chain_walker.sv
verilog/hash_map.sv
sim/hash_map_assertions.sv
sim/hash_map_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, and judge the result from the simulation log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps -f sources.f \
  --top-module hash_map_tb -o hash_map_sim > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/hash_map_sim > sim.log 2>&1
cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "simulation failed"; exit 1; }
grep -q "NO ERRORS" sim.log || { echo "simulation failed"; exit 1; }
echo "simulation passed"
